// ==== silent_array_pkg.sv ====
// Array geometry for the transducer driver
// Number of transducers and the widths of the duty, phase and step words
`default_nettype none

package silent_array_pkg;

  // Kept small here, any count works
  localparam int num_trans = 8;

  localparam int trans_idx_w = $clog2(num_trans);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int duty_w = 9;
  localparam int phase_w = 9;
  localparam int step_w = 9;  // Largest change per update

endpackage

`default_nettype wire

// ==== silent_timing_pkg.sv ====
// Timing and arithmetic constants for the transducer driver
// PWM period, the short-way threshold and the adder pipeline depth
`default_nettype none

package silent_timing_pkg;

  // One full PWM cycle, equal to the phase modulus of 2**phase_w
  localparam int pwm_period = 512;

  // A phase difference beyond this goes the other way around
  localparam int half_period = pwm_period / 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arithmetic
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int addsub_latency = 2;  // Register stages in addsub

  // Signed width that holds differences and the unfolded phase sum
  localparam int calc_w = silent_array_pkg::duty_w + 2;

endpackage

`default_nettype wire

// ==== addsub.sv ====
// Pipelined signed adder and subtractor
// Operands are registered, then the sum or difference is registered again
`timescale 1ns/1ps
`default_nettype none

module addsub (
  input  logic                                     CLK,
  input  logic signed [silent_timing_pkg::calc_w-1:0] a,
  input  logic signed [silent_timing_pkg::calc_w-1:0] b,
  input  logic                                     add,
  output logic signed [silent_timing_pkg::calc_w-1:0] s
);

  import silent_timing_pkg::*;

  logic signed [calc_w-1:0] a_q;
  logic signed [calc_w-1:0] b_q;
  logic                     add_q;

  always_ff @(posedge CLK) begin
    a_q   <= a;
    b_q   <= b;
    add_q <= add;
    s     <= add_q ? a_q + b_q : a_q - b_q;  // Second stage
  end

endmodule

`default_nettype wire

// ==== target_ram.sv ====
// Target memory for the per-transducer duty and phase
// Host writes land at any time; an accepted update freezes a copy of the
// table and streams it out one entry per cycle
`timescale 1ns/1ps
`default_nettype none

module target_ram (
  input  logic                                     CLK,
  input  logic                                     rst_n,
  input  logic                                     update,
  input  logic                                     busy,
  input  logic                                     wr_en,
  input  logic [silent_array_pkg::trans_idx_w-1:0] wr_idx,
  input  logic [silent_array_pkg::duty_w-1:0]      wr_duty,
  input  logic [silent_array_pkg::phase_w-1:0]     wr_phase,
  output logic                                     din_valid,
  output logic [silent_array_pkg::duty_w-1:0]      din_duty,
  output logic [silent_array_pkg::phase_w-1:0]     din_phase
);

  import silent_array_pkg::*;

  logic [duty_w-1:0]      duty_mem   [num_trans];
  logic [phase_w-1:0]     phase_mem  [num_trans];
  logic [duty_w-1:0]      duty_snap  [num_trans];
  logic [phase_w-1:0]     phase_snap [num_trans];
  logic [trans_idx_w-1:0] rd_idx;
  logic [trans_idx_w-1:0] last_idx;
  logic                   accept;

  assign accept   = update && !busy;
  assign last_idx = trans_idx_w'(num_trans - 1);

  // Writes after the snapshot only show up at the next update
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      duty_mem[wr_idx]  <= wr_duty;
      phase_mem[wr_idx] <= wr_phase;
    end
    if (accept) begin
      duty_snap  <= duty_mem;
      phase_snap <= phase_mem;
    end
  end

  // Read index parks on the last entry between streams
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      din_valid <= 1'b0;
      rd_idx    <= last_idx;
    end else begin
      din_valid <= accept;  // Marks entry 0 only
      if (accept) begin
        rd_idx <= '0;
      end else if (rd_idx != last_idx) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  assign din_duty  = duty_snap[rd_idx];
  assign din_phase = phase_snap[rd_idx];

endmodule

`default_nettype wire

// ==== silencer.sv ====
// Slew-rate limiter for transducer duty and phase
// Each update moves every stored value toward its target by at most step;
// the phase goes the short way around the period and is folded back into range
`timescale 1ns/1ps
`default_nettype none

module silencer (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [silent_array_pkg::step_w-1:0]  step,
  input  logic                                 din_valid,
  input  logic [silent_array_pkg::duty_w-1:0]  din_duty,
  input  logic [silent_array_pkg::phase_w-1:0] din_phase,
  output logic                                 dout_valid,
  output logic [silent_array_pkg::duty_w-1:0]  dout_duty,
  output logic [silent_array_pkg::phase_w-1:0] dout_phase,
  output logic                                 busy
);

  import silent_array_pkg::*;
  import silent_timing_pkg::*;

  typedef enum logic {
    WAITING,
    RUNNING
  } state_t;

  state_t state;

  logic [duty_w-1:0]             cur_duty  [num_trans];
  logic [phase_w-1:0]            cur_phase [num_trans];
  logic [duty_w-1:0]             tgt_duty;
  logic [phase_w-1:0]            tgt_phase;
  logic signed [calc_w-1:0]      step_pos, step_neg;
  logic signed [calc_w-1:0]      period_s, half_s;
  logic signed [calc_w-1:0]      duty_diff, phase_diff, phase_short;
  logic signed [calc_w-1:0]      duty_sum, phase_sum, phase_folded;
  logic signed [calc_w-1:0]      dir_b, fold_b;
  logic                          dir_add, fold_add;
  logic signed [calc_w-1:0]      duty_diff_q [addsub_latency];
  logic signed [calc_w-1:0]      duty_sum_q  [addsub_latency];
  logic [4*addsub_latency-1:0]   vpipe;  // Stage valid, one bit per cycle of delay
  logic                          step_active;
  logic [trans_idx_w-1:0]        step_idx, calc_idx, set_idx, last_idx;
  logic                          calc_en, set_en;

  function automatic logic signed [calc_w-1:0] clamp(
    input logic signed [calc_w-1:0] d,
    input logic signed [calc_w-1:0] hi,
    input logic signed [calc_w-1:0] lo
  );
    if (d > hi) return hi;
    if (d < lo) return lo;
    return d;
  endfunction

  assign period_s = signed'(calc_w'(pwm_period));
  assign half_s   = signed'(calc_w'(half_period));
  assign last_idx = trans_idx_w'(num_trans - 1);
  assign calc_en  = vpipe[2*addsub_latency-1];
  assign set_en   = vpipe[4*addsub_latency-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arithmetic chain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  addsub sub_duty_step (.CLK(CLK), .a(signed'(calc_w'(tgt_duty))),
    .b(signed'(calc_w'(cur_duty[step_idx]))), .add(1'b0), .s(duty_diff));

  addsub sub_phase_step (.CLK(CLK), .a(signed'(calc_w'(tgt_phase))),
    .b(signed'(calc_w'(cur_phase[step_idx]))), .add(1'b0), .s(phase_diff));

  addsub dir_phase (.CLK(CLK), .a(phase_diff), .b(dir_b), .add(dir_add), .s(phase_short));

  addsub add_duty (.CLK(CLK), .a(signed'(calc_w'(cur_duty[calc_idx]))),
    .b(clamp(duty_diff_q[addsub_latency-1], step_pos, step_neg)), .add(1'b1), .s(duty_sum));

  addsub add_phase (.CLK(CLK), .a(signed'(calc_w'(cur_phase[calc_idx]))),
    .b(clamp(phase_short, step_pos, step_neg)), .add(1'b1), .s(phase_sum));

  addsub fold_phase (.CLK(CLK), .a(phase_sum), .b(fold_b), .add(fold_add), .s(phase_folded));

  // Going the other way around is shorter past half a period
  always_comb begin
    dir_b   = '0;
    dir_add = 1'b1;
    if (phase_diff > half_s) begin
      dir_b   = period_s;
      dir_add = 1'b0;
    end else if (phase_diff < -half_s) begin
      dir_b = period_s;
    end
  end

  always_comb begin
    fold_b   = '0;
    fold_add = 1'b1;
    if (phase_sum >= period_s) begin
      fold_b   = period_s;
      fold_add = 1'b0;
    end else if (phase_sum[calc_w-1]) begin
      fold_b = period_s;  // Negative, wrap up
    end
  end

  // Duty runs two cycles ahead of phase and waits here
  always_ff @(posedge CLK) begin
    tgt_duty       <= din_duty;
    tgt_phase      <= din_phase;
    duty_diff_q[0] <= duty_diff;
    duty_sum_q[0]  <= duty_sum;
    for (int i = 1; i < addsub_latency; i++) begin
      duty_diff_q[i] <= duty_diff_q[i-1];
      duty_sum_q[i]  <= duty_sum_q[i-1];
    end
    if (start && !busy) begin
      step_pos <= signed'(calc_w'(step));
      step_neg <= -signed'(calc_w'(step));
    end
    if (set_en) begin
      dout_duty  <= duty_sum_q[addsub_latency-1][duty_w-1:0];
      dout_phase <= phase_folded[phase_w-1:0];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state       <= WAITING;
      busy        <= 1'b0;
      dout_valid  <= 1'b0;
      step_active <= 1'b0;
      vpipe       <= '0;
      step_idx    <= '0;
      calc_idx    <= '0;
      set_idx     <= '0;
      cur_duty    <= '{default: '0};
      cur_phase   <= '{default: '0};
    end else begin
      vpipe      <= {vpipe[4*addsub_latency-2:0], step_active};
      dout_valid <= set_en;
      if (start && !busy) begin
        busy <= 1'b1;
      end else if (state == WAITING && dout_valid) begin
        busy <= 1'b0;  // Last output has just gone out
      end
      case (state)
        WAITING: begin
          if (din_valid) begin
            state       <= RUNNING;
            step_active <= 1'b1;
            step_idx    <= '0;
            calc_idx    <= '0;
            set_idx     <= '0;
          end
        end
        RUNNING: begin
          if (step_active) begin
            step_idx <= step_idx + 1'b1;
            if (step_idx == last_idx) step_active <= 1'b0;
          end
          if (calc_en) calc_idx <= calc_idx + 1'b1;
          if (set_en) begin
            cur_duty[set_idx]  <= duty_sum_q[addsub_latency-1][duty_w-1:0];
            cur_phase[set_idx] <= phase_folded[phase_w-1:0];
            set_idx            <= set_idx + 1'b1;
            if (set_idx == last_idx) state <= WAITING;
          end
        end
        default: state <= WAITING;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== pwm_array.sv ====
// PWM generator bank, one pulse output per transducer
// Streamed values land in shadow registers and move to the active set
// at the end of each period, so a pulse never changes mid-cycle
`timescale 1ns/1ps
`default_nettype none

module pwm_array (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic                                 dout_valid,
  input  logic [silent_array_pkg::duty_w-1:0]  dout_duty,
  input  logic [silent_array_pkg::phase_w-1:0] dout_phase,
  output logic [silent_array_pkg::num_trans-1:0] pwm_out
);

  import silent_array_pkg::*;
  import silent_timing_pkg::*;

  logic [duty_w-1:0]      shd_duty  [num_trans];
  logic [phase_w-1:0]     shd_phase [num_trans];
  logic [duty_w-1:0]      act_duty  [num_trans];
  logic [phase_w-1:0]     act_phase [num_trans];
  logic [trans_idx_w-1:0] wr_idx;
  logic [phase_w-1:0]     cnt;
  logic                   cnt_last;

  assign cnt_last = (cnt == phase_w'(pwm_period - 1));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cnt       <= '0;
      wr_idx    <= '0;
      shd_duty  <= '{default: '0};
      shd_phase <= '{default: '0};
      act_duty  <= '{default: '0};
      act_phase <= '{default: '0};
    end else begin
      cnt <= cnt_last ? '0 : cnt + 1'b1;
      if (dout_valid) begin
        shd_duty[wr_idx]  <= dout_duty;
        shd_phase[wr_idx] <= dout_phase;
        // Index follows the stream order
        wr_idx <= (wr_idx == trans_idx_w'(num_trans - 1)) ? '0 : wr_idx + 1'b1;
      end
      if (cnt_last) begin
        act_duty  <= shd_duty;
        act_phase <= shd_phase;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pulse compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Counter minus phase wraps naturally in phase_w bits
  always_comb begin
    for (int i = 0; i < num_trans; i++) begin
      pwm_out[i] = (phase_w'(cnt - act_phase[i]) < act_duty[i]);
    end
  end

endmodule

`default_nettype wire

// ==== silent_top.sv ====
// Ultrasound array driver top level
// Target memory feeds the silencer, whose smoothed stream drives the PWM bank
`timescale 1ns/1ps
`default_nettype none

module silent_top (
  input  logic                                     CLK,
  input  logic                                     rst_n,
  input  logic                                     update,
  input  logic [silent_array_pkg::step_w-1:0]      step,
  input  logic                                     wr_en,
  input  logic [silent_array_pkg::trans_idx_w-1:0] wr_idx,
  input  logic [silent_array_pkg::duty_w-1:0]      wr_duty,
  input  logic [silent_array_pkg::phase_w-1:0]     wr_phase,
  output logic                                     busy,
  output logic                                     drive_valid,
  output logic [silent_array_pkg::duty_w-1:0]      drive_duty,
  output logic [silent_array_pkg::phase_w-1:0]     drive_phase,
  output logic [silent_array_pkg::num_trans-1:0]   pwm_out
);

  import silent_array_pkg::*;

  logic               din_valid;
  logic [duty_w-1:0]  din_duty;
  logic [phase_w-1:0] din_phase;

  target_ram target_ram_inst (
    .CLK(CLK), .rst_n(rst_n), .update(update), .busy(busy),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_duty(wr_duty), .wr_phase(wr_phase),
    .din_valid(din_valid), .din_duty(din_duty), .din_phase(din_phase)
  );

  // Update goes straight in, the silencer drops it while busy
  silencer silencer_inst (
    .CLK(CLK), .rst_n(rst_n), .start(update), .step(step),
    .din_valid(din_valid), .din_duty(din_duty), .din_phase(din_phase),
    .dout_valid(drive_valid), .dout_duty(drive_duty), .dout_phase(drive_phase),
    .busy(busy)
  );

  pwm_array pwm_array_inst (
    .CLK(CLK), .rst_n(rst_n), .dout_valid(drive_valid),
    .dout_duty(drive_duty), .dout_phase(drive_phase), .pwm_out(pwm_out)
  );

endmodule

`default_nettype wire

// ==== silent_checker.sv ====
// Handshake checker for the array driver
// Watches update, busy and the drive stream
`timescale 1ns/1ps
`default_nettype none

module silent_checker (
  input logic CLK,
  input logic rst_n,
  input logic update,
  input logic busy,
  input logic drive_valid
);

  import silent_array_pkg::*;

  int valid_cnt = 0;
  int n_fail_idle = 0;
  int n_fail_rise = 0;
  int n_fail_count = 0;

  // Valid cycles since the last accepted update
  always_ff @(posedge CLK) begin
    if (!rst_n || (update && !busy)) valid_cnt <= 0;
    else if (drive_valid) valid_cnt <= valid_cnt + 1;
  end

  valid_needs_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    drive_valid |-> busy)
  else begin
    n_fail_idle++;
    $error("drive_valid high while busy is low");
  end

  busy_follows_update: assert property (@(posedge CLK) disable iff (!rst_n)
    (update && !busy) |=> busy)
  else begin
    n_fail_rise++;
    $error("busy did not rise after an accepted update");
  end

  stream_length: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(busy) |-> valid_cnt == num_trans)
  else begin
    n_fail_count++;
    $error("busy period carried %0d valid cycles", valid_cnt);
  end

endmodule

`default_nettype wire

// ==== tb_silent.sv ====
// Testbench for the ultrasound array driver
// Random targets and steps are checked against a slew-rate and PWM model
`timescale 1ns/1ps
`default_nettype none

module tb_silent;

  import silent_array_pkg::*;
  import silent_timing_pkg::*;

  localparam int n_slew     = 20;
  localparam int n_wrap     = 10;
  localparam int n_updates  = n_slew + n_wrap + 4;  // Plus wrap entry, converge, busy, pwm
  localparam int n_tests    = 6;
  localparam int idle_limit = num_trans + 40;  // Cycles allowed for one update
  localparam int watchdog_cycles =
    n_updates * (num_trans + 40) + n_tests * 2 * pwm_period + 3000;

  logic                   CLK;
  logic                   rst_n;
  logic                   update;
  logic [step_w-1:0]      step;
  logic                   wr_en;
  logic [trans_idx_w-1:0] wr_idx;
  logic [duty_w-1:0]      wr_duty;
  logic [phase_w-1:0]     wr_phase;
  logic                   busy;
  logic                   drive_valid;
  logic [duty_w-1:0]      drive_duty;
  logic [phase_w-1:0]     drive_phase;
  logic [num_trans-1:0]   pwm_out;

  int seed = 32'h1c9c3520;
  int n_checks = 0;
  int n_mismatch = 0;
  int n_other = 0;
  int tgt_d [num_trans];
  int tgt_p [num_trans];
  int cur_d [num_trans];  // Model of the silencer's stored values
  int cur_p [num_trans];
  int got_d [$];
  int got_p [$];
  int pwm_cnt;

  silent_top silent_top_inst (
    .CLK(CLK), .rst_n(rst_n), .update(update), .step(step),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_duty(wr_duty), .wr_phase(wr_phase),
    .busy(busy), .drive_valid(drive_valid), .drive_duty(drive_duty),
    .drive_phase(drive_phase), .pwm_out(pwm_out)
  );

  bind silent_top silent_checker checker_inst (
    .CLK(CLK), .rst_n(rst_n), .update(update), .busy(busy), .drive_valid(drive_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Period counter of the PWM model starts at 0 on the first cycle after reset
  always @(posedge CLK) begin
    if (!rst_n) pwm_cnt <= 0;
    else pwm_cnt <= (pwm_cnt + 1) % pwm_period;
  end

  always @(negedge CLK) begin
    if (drive_valid) begin
      got_d.push_back(int'(drive_duty));
      got_p.push_back(int'(drive_phase));
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Model and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic expect_equal(input string name, input int expected, input int actual);
    n_checks++;
    if (expected !== actual) begin
      n_mismatch++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic int clamp_step(input int d, input int s);
    if (d > s) return s;
    if (d < -s) return -s;
    return d;
  endfunction

  function automatic void apply_model(input int s);
    int dp;
    for (int i = 0; i < num_trans; i++) begin
      cur_d[i] = cur_d[i] + clamp_step(tgt_d[i] - cur_d[i], s);
      dp = tgt_p[i] - cur_p[i];
      if (dp > half_period) dp -= pwm_period;  // Shorter to go down through 0
      else if (dp < -half_period) dp += pwm_period;
      cur_p[i] = (cur_p[i] + clamp_step(dp, s) + pwm_period) % pwm_period;
    end
  endfunction

  function automatic int expected_pwm();
    int v;
    v = 0;
    for (int i = 0; i < num_trans; i++) begin
      if ((pwm_cnt - cur_p[i] + pwm_period) % pwm_period < cur_d[i]) v |= 1 << i;
    end
    return v;
  endfunction

  task automatic load_targets(input int d_lo, input int d_span, input int p_lo, input int p_span);
    for (int i = 0; i < num_trans; i++) begin
      @(posedge CLK);
      tgt_d[i] = d_lo + rand_below(d_span);
      tgt_p[i] = (p_lo + rand_below(p_span)) % pwm_period;
      wr_en    <= 1'b1;
      wr_idx   <= trans_idx_w'(i);
      wr_duty  <= duty_w'(tgt_d[i]);
      wr_phase <= phase_w'(tgt_p[i]);
    end
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic compare_stream(input string name);
    expect_equal({name, " count"}, num_trans, got_d.size());
    for (int i = 0; i < got_d.size() && i < num_trans; i++) begin
      expect_equal($sformatf("%s duty %0d", name, i), cur_d[i], got_d[i]);
      expect_equal($sformatf("%s phase %0d", name, i), cur_p[i], got_p[i]);
    end
  endtask

  // One update with an optional second strobe that lands while busy
  task automatic run_update(input string name, input int s, input bit busy_strobe);
    int waited;
    got_d.delete();
    got_p.delete();
    @(posedge CLK);
    update <= 1'b1;
    step   <= step_w'(s);
    @(posedge CLK);
    update <= 1'b0;
    apply_model(s);
    if (busy_strobe) begin
      repeat (3) @(posedge CLK);
      update <= 1'b1;
      step   <= step_w'(1);
      @(posedge CLK);
      update <= 1'b0;
    end
    waited = 0;
    @(negedge CLK);
    while (busy && waited < idle_limit) begin
      @(negedge CLK);
      waited++;
    end
    if (busy) begin
      n_other++;
      $display("%s: busy still high %0d cycles after the update", name, idle_limit);
    end
    compare_stream(name);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_n    = 1'b0;
    update   = 1'b0;
    step     = '0;
    wr_en    = 1'b0;
    wr_idx   = '0;
    wr_duty  = '0;
    wr_phase = '0;
    for (int i = 0; i < num_trans; i++) begin
      cur_d[i] = 0;
      cur_p[i] = 0;
    end
    repeat (10) @(posedge CLK);
    rst_n <= 1'b1;

    repeat (100) begin
      @(negedge CLK);
      expect_equal("idle busy", 0, int'(busy));
      expect_equal("idle drive_valid", 0, int'(drive_valid));
      expect_equal("idle pwm_out", 0, int'(pwm_out));
    end

    for (int u = 0; u < n_slew; u++) begin
      load_targets(0, 512, 0, 512);
      run_update("duty slew", 1 + rand_below(64), 1'b0);
    end

    // Phase targets straddle 0 and 511 so the short way crosses the wrap
    load_targets(0, 512, 500, 24);
    run_update("phase wrap", 511, 1'b0);
    for (int u = 0; u < n_wrap; u++) begin
      load_targets(0, 512, 500, 24);
      run_update("phase wrap", 1 + rand_below(16), 1'b0);
    end

    load_targets(0, 512, 0, 512);
    run_update("converge", 511, 1'b0);
    for (int i = 0; i < got_d.size() && i < num_trans; i++) begin
      expect_equal($sformatf("converge target duty %0d", i), tgt_d[i], got_d[i]);
      expect_equal($sformatf("converge target phase %0d", i), tgt_p[i], got_p[i]);
    end

    load_targets(0, 512, 0, 512);
    run_update("busy strobe", 1 + rand_below(64), 1'b1);
    repeat (40) @(negedge CLK);
    expect_equal("busy strobe late count", num_trans, got_d.size());
    expect_equal("busy strobe idle", 0, int'(busy));

    load_targets(0, 512, 0, 512);
    run_update("pwm", 1 + rand_below(511), 1'b0);
    @(negedge CLK);
    while (pwm_cnt != 0) @(negedge CLK);  // Active set is loaded at the wrap
    for (int t = 0; t < pwm_period; t++) begin
      expect_equal("pwm", expected_pwm(), int'(pwm_out));
      @(negedge CLK);
    end

    n_other += silent_top_inst.checker_inst.n_fail_idle;
    n_other += silent_top_inst.checker_inst.n_fail_rise;
    n_other += silent_top_inst.checker_inst.n_fail_count;
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== silent.f ====
silent_array_pkg.sv
silent_timing_pkg.sv
addsub.sv
target_ram.sv
silencer.sv
pwm_array.sv
silent_top.sv
silent_checker.sv
tb_silent.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f silent.f --top-module tb_silent -o sim_silent

out=$(./obj_dir/sim_silent +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -qF "TESTS PASSED"; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
